// File: src/mb_proto_pkg.sv
/*
  Modbus RTU protocol constants and types shared by the slave.
  Referenced by scoped names from the frame logic and the CRC engine.
*/
`default_nettype none

package mb_proto_pkg;

  // ====================
  // Frame data types
  // ====================

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [15:0] crc_t;

  // Byte position inside a frame
  typedef logic [7:0]  count_t;

  // ====================
  // Function codes
  // ====================

  localparam byte_t FC_READ_HOLDING = 8'h03;
  localparam byte_t FC_WRITE_SINGLE = 8'h06;

  // CRC-16/MODBUS, reflected form
  localparam crc_t CRC_INIT = 16'hFFFF;
  localparam crc_t CRC_POLY = 16'hA001;

  // Both supported requests are 8 bytes including CRC
  localparam count_t REQ_LEN      = 8'd8;
  // Station, function and byte count ahead of read data
  localparam count_t READ_HDR_LEN = 8'd3;

endpackage

`default_nettype wire

// File: src/mb_map_pkg.sv
/*
  Holding-register map of the slave.
  Depth of the register image, its index type and the read limit.
*/
`default_nettype none

package mb_map_pkg;

  // Number of 16-bit words in the holding-register image
  localparam int REG_WORDS = 64;

  // Image index, address offset taken modulo REG_WORDS
  typedef logic [5:0] reg_idx_t;

  // Largest quantity accepted by a read request
  localparam mb_proto_pkg::word_t MAX_READ_QTY = 16'd32;

endpackage

`default_nettype wire

// File: src/mb_crc16.sv
/*
  Serial CRC-16/MODBUS engine folding one byte per enable.
  clr reloads the start value; clr with en folds the byte into a fresh CRC.
*/
`timescale 1ns/1ps
`default_nettype none

module mb_crc16 (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                clr,
  input  wire logic                en,
  input  wire mb_proto_pkg::byte_t data,
  output mb_proto_pkg::crc_t       crc
);

  // Eight shift steps, LSB first
  function automatic mb_proto_pkg::crc_t crc_fold(input mb_proto_pkg::crc_t c_in,
                                                  input mb_proto_pkg::byte_t d);
    mb_proto_pkg::crc_t c;
    c = c_in ^ {8'h00, d};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ mb_proto_pkg::CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      crc <= mb_proto_pkg::CRC_INIT;
    end else if (clr && en) begin
      // First byte of a new frame
      crc <= crc_fold(mb_proto_pkg::CRC_INIT, data);
    end else if (clr) begin
      crc <= mb_proto_pkg::CRC_INIT;
    end else if (en) begin
      crc <= crc_fold(crc, data);
    end
  end

endmodule

`default_nettype wire

// File: src/mb_byte_counter.sv
/*
  Frame byte counter used for both reception and transmission.
  at_end flags the end of the response when the count reaches resp_len.
*/
`timescale 1ns/1ps
`default_nettype none

module mb_byte_counter (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 clr,
  input  wire logic                 inc,
  input  wire mb_proto_pkg::count_t resp_len,
  output mb_proto_pkg::count_t      count,
  output logic                      at_end
);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (clr) begin
      // A byte in the clearing cycle becomes position 0
      count <= inc ? 8'd1 : 8'd0;
    end else if (inc && count != 8'hFF) begin
      count <= count + 8'd1;
    end
  end

  assign at_end = (count == resp_len);

endmodule

`default_nettype wire

// File: src/mb_rx_fields.sv
/*
  Request field capture by byte position, plus request judgement.
  Fields are written while cap_en is high; resp_len and req_ok follow them.
*/
`timescale 1ns/1ps
`default_nettype none

module mb_rx_fields (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 cap_en,
  input  wire mb_proto_pkg::count_t count,
  input  wire mb_proto_pkg::byte_t  rx_b,
  output mb_proto_pkg::byte_t       station,
  output mb_proto_pkg::byte_t       func,
  output mb_proto_pkg::word_t       start_addr,
  output mb_proto_pkg::word_t       value,
  output mb_proto_pkg::count_t      resp_len,
  output logic                      req_ok
);

  logic is_read;
  logic is_write;

  // Function code decides whether a request is served at all
  always_ff @(posedge clk) begin
    if (rst) begin
      func <= '0;
    end else if (cap_en && count == 8'd1) begin
      func <= rx_b;
    end
  end

  // Header fields, big endian on the wire
  always_ff @(posedge clk) begin
    if (cap_en) begin
      case (count)
        8'd0: station          <= rx_b;
        8'd2: start_addr[15:8] <= rx_b;
        8'd3: start_addr[7:0]  <= rx_b;
        8'd4: value[15:8]      <= rx_b;
        8'd5: value[7:0]       <= rx_b;
        default: ;
      endcase
    end
  end

  assign is_read  = (func == mb_proto_pkg::FC_READ_HOLDING);
  assign is_write = (func == mb_proto_pkg::FC_WRITE_SINGLE);

  // Write echoes the request; read is header, 2*qty data bytes, CRC
  assign resp_len = is_write ? mb_proto_pkg::REQ_LEN :
                    mb_proto_pkg::READ_HDR_LEN + {value[6:0], 1'b0} + 8'd2;

  assign req_ok = is_write ||
                  (is_read && value != 16'd0 && value <= mb_map_pkg::MAX_READ_QTY);

endmodule

`default_nettype wire

// File: src/mb_holding_regs.sv
/*
  Holding-register image of 64 words.
  Modbus addresses map to the image relative to cfg_map_base, modulo the depth.
  Synchronous write port, combinational read port.
*/
`timescale 1ns/1ps
`default_nettype none

module mb_holding_regs (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire mb_proto_pkg::word_t cfg_map_base,
  input  wire logic                we,
  input  wire mb_proto_pkg::word_t wr_addr,
  input  wire mb_proto_pkg::word_t wr_data,
  input  wire mb_proto_pkg::word_t rd_addr,
  output mb_proto_pkg::word_t      rd_data
);

  mb_proto_pkg::word_t regs [mb_map_pkg::REG_WORDS];

  mb_map_pkg::reg_idx_t wr_idx;
  mb_map_pkg::reg_idx_t rd_idx;

  // Offset from the map base, low bits only
  function automatic mb_map_pkg::reg_idx_t to_idx(input mb_proto_pkg::word_t addr,
                                                  input mb_proto_pkg::word_t base);
    mb_proto_pkg::word_t ofs;
    ofs = addr - base;
    return mb_map_pkg::reg_idx_t'(ofs);
  endfunction

  assign wr_idx = to_idx(wr_addr, cfg_map_base);
  assign rd_idx = to_idx(rd_addr, cfg_map_base);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < mb_map_pkg::REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

// File: src/mb_tx_mux.sv
/*
  Response byte select by position.
  Write responses echo the request, read responses stream register words.
  The last two positions carry the CRC, low byte first.
*/
`timescale 1ns/1ps
`default_nettype none

module mb_tx_mux (
  input  wire mb_proto_pkg::count_t count,
  input  wire mb_proto_pkg::byte_t  station,
  input  wire mb_proto_pkg::byte_t  func,
  input  wire mb_proto_pkg::word_t  start_addr,
  input  wire mb_proto_pkg::word_t  value,
  input  wire mb_proto_pkg::word_t  rd_data,
  input  wire mb_proto_pkg::crc_t   crc,
  input  wire mb_proto_pkg::count_t resp_len,
  output mb_proto_pkg::word_t       rd_addr,
  output mb_proto_pkg::byte_t       tx_byte,
  output logic                      is_crc
);

  // Position relative to the first read data byte
  mb_proto_pkg::count_t data_off;
  mb_proto_pkg::count_t crc_pos;

  assign data_off = count - mb_proto_pkg::READ_HDR_LEN;
  assign crc_pos  = resp_len - 8'd2;

  // Two bytes per word, so the word number is data_off / 2
  assign rd_addr = start_addr + {9'd0, data_off[7:1]};

  // Keeps the CRC bytes out of the transmit CRC engine
  assign is_crc = (count >= crc_pos);

  always_comb begin
    tx_byte = '0;
    if (is_crc) begin
      tx_byte = (count == crc_pos) ? crc[7:0] : crc[15:8];
    end else if (func == mb_proto_pkg::FC_WRITE_SINGLE) begin
      case (count)
        8'd0: tx_byte = station;
        8'd1: tx_byte = func;
        8'd2: tx_byte = start_addr[15:8];
        8'd3: tx_byte = start_addr[7:0];
        8'd4: tx_byte = value[15:8];
        8'd5: tx_byte = value[7:0];
        default: tx_byte = '0;
      endcase
    end else begin
      case (count)
        8'd0: tx_byte = station;
        8'd1: tx_byte = func;
        // Byte count, quantity is at most 32
        8'd2: tx_byte = {value[6:0], 1'b0};
        // High byte of each word goes first
        default: tx_byte = data_off[0] ? rd_data[7:0] : rd_data[15:8];
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/mb_frame_fsm.sv
/*
  Frame sequencer of the slave: collect, check, execute, send.
  Drives the counter, both CRC engines, field capture and the register write,
  and registers the outgoing byte stream.
*/
`timescale 1ns/1ps
`default_nettype none

module mb_frame_fsm (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 rx_b_v,
  input  wire logic                 frame_start,
  input  wire logic                 frame_end,
  input  wire logic                 tx_b_rdy,
  input  wire mb_proto_pkg::count_t count,
  input  wire logic                 at_end,
  input  wire logic                 req_ok,
  input  wire logic                 is_crc,
  input  wire mb_proto_pkg::crc_t   rx_crc,
  input  wire mb_proto_pkg::byte_t  func,
  input  wire mb_proto_pkg::byte_t  tx_byte,
  output logic                      cnt_clr,
  output logic                      cnt_inc,
  output logic                      rx_crc_clr,
  output logic                      rx_crc_en,
  output logic                      tx_crc_clr,
  output logic                      tx_crc_en,
  output logic                      cap_en,
  output logic                      reg_we,
  output mb_proto_pkg::byte_t       tx_b,
  output logic                      tx_b_v,
  output logic                      stat_crc_err
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COLLECT,
    ST_CHECK,
    ST_EXEC,
    ST_SEND
  } state_t;

  state_t state;
  state_t state_nxt;

  logic len_ok;
  logic crc_bad;
  logic tx_fire;

  assign len_ok  = (count == mb_proto_pkg::REQ_LEN);
  // Residual over data plus CRC bytes is zero for a good frame
  assign crc_bad = len_ok && (rx_crc != 16'h0000);
  assign tx_fire = (state == ST_SEND) && !at_end && tx_b_rdy;

  // ====================
  // Next state and strobes
  // ====================

  always_comb begin
    state_nxt  = state;
    cnt_clr    = 1'b0;
    cnt_inc    = 1'b0;
    rx_crc_clr = 1'b0;
    rx_crc_en  = 1'b0;
    tx_crc_clr = 1'b0;
    tx_crc_en  = 1'b0;
    cap_en     = 1'b0;
    reg_we     = 1'b0;
    case (state)
      ST_IDLE: begin
        // Hold counter and CRC at start so a first byte lands at position 0
        cnt_clr    = 1'b1;
        rx_crc_clr = 1'b1;
        if (frame_start) begin
          state_nxt = ST_COLLECT;
          cnt_inc   = rx_b_v;
          rx_crc_en = rx_b_v;
          cap_en    = rx_b_v;
        end
      end
      ST_COLLECT: begin
        cnt_inc   = rx_b_v;
        rx_crc_en = rx_b_v;
        cap_en    = rx_b_v;
        if (frame_end) begin
          state_nxt = ST_CHECK;
        end
      end
      ST_CHECK: begin
        cnt_clr   = 1'b1;
        state_nxt = (len_ok && !crc_bad && req_ok) ? ST_EXEC : ST_IDLE;
      end
      ST_EXEC: begin
        tx_crc_clr = 1'b1;
        reg_we     = (func == mb_proto_pkg::FC_WRITE_SINGLE);
        state_nxt  = ST_SEND;
      end
      ST_SEND: begin
        if (at_end) begin
          cnt_clr   = 1'b1;
          state_nxt = ST_IDLE;
        end else if (tx_b_rdy) begin
          cnt_inc   = 1'b1;
          tx_crc_en = !is_crc;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // ====================
  // Registers
  // ====================

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      tx_b_v       <= 1'b0;
      stat_crc_err <= 1'b0;
    end else begin
      state  <= state_nxt;
      tx_b_v <= tx_fire;
      if (state == ST_CHECK && crc_bad) begin
        stat_crc_err <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_fire) begin
      tx_b <= tx_byte;
    end
  end

endmodule

`default_nettype wire

// File: src/mb_slave_top.sv
/*
  Modbus RTU slave top level serving function codes 03 and 06.
  Takes bytes and frame marks from a byte-stream bridge and returns
  the response bytes under tx_b_rdy flow control.
*/
`timescale 1ns/1ps
`default_nettype none

module mb_slave_top (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire mb_proto_pkg::word_t cfg_map_base,
  input  wire mb_proto_pkg::byte_t rx_b,
  input  wire logic                rx_b_v,
  input  wire logic                frame_start,
  input  wire logic                frame_end,
  output mb_proto_pkg::byte_t      tx_b,
  output logic                     tx_b_v,
  input  wire logic                tx_b_rdy,
  output logic                     stat_crc_err
);

  // Sequencer strobes
  logic cnt_clr;
  logic cnt_inc;
  logic rx_crc_clr;
  logic rx_crc_en;
  logic tx_crc_clr;
  logic tx_crc_en;
  logic cap_en;
  logic reg_we;

  mb_proto_pkg::count_t count;
  mb_proto_pkg::count_t resp_len;
  logic                 at_end;
  logic                 req_ok;
  logic                 is_crc;

  // Request fields
  mb_proto_pkg::byte_t  station;
  mb_proto_pkg::byte_t  func;
  mb_proto_pkg::word_t  start_addr;
  mb_proto_pkg::word_t  value;

  mb_proto_pkg::crc_t   rx_crc;
  mb_proto_pkg::crc_t   tx_crc;
  mb_proto_pkg::word_t  rd_addr;
  mb_proto_pkg::word_t  rd_data;
  mb_proto_pkg::byte_t  tx_byte;

  mb_frame_fsm u_fsm (
    .clk(clk), .rst(rst),
    .rx_b_v(rx_b_v), .frame_start(frame_start), .frame_end(frame_end),
    .tx_b_rdy(tx_b_rdy), .count(count), .at_end(at_end), .req_ok(req_ok),
    .is_crc(is_crc), .rx_crc(rx_crc), .func(func), .tx_byte(tx_byte),
    .cnt_clr(cnt_clr), .cnt_inc(cnt_inc),
    .rx_crc_clr(rx_crc_clr), .rx_crc_en(rx_crc_en),
    .tx_crc_clr(tx_crc_clr), .tx_crc_en(tx_crc_en),
    .cap_en(cap_en), .reg_we(reg_we),
    .tx_b(tx_b), .tx_b_v(tx_b_v), .stat_crc_err(stat_crc_err)
  );

  mb_byte_counter u_cnt (
    .clk(clk), .rst(rst), .clr(cnt_clr), .inc(cnt_inc),
    .resp_len(resp_len), .count(count), .at_end(at_end)
  );

  mb_rx_fields u_fields (
    .clk(clk), .rst(rst), .cap_en(cap_en), .count(count), .rx_b(rx_b),
    .station(station), .func(func), .start_addr(start_addr), .value(value),
    .resp_len(resp_len), .req_ok(req_ok)
  );

  // Write single uses the address and value fields directly
  mb_holding_regs u_regs (
    .clk(clk), .rst(rst), .cfg_map_base(cfg_map_base),
    .we(reg_we), .wr_addr(start_addr), .wr_data(value),
    .rd_addr(rd_addr), .rd_data(rd_data)
  );

  mb_tx_mux u_mux (
    .count(count), .station(station), .func(func),
    .start_addr(start_addr), .value(value), .rd_data(rd_data),
    .crc(tx_crc), .resp_len(resp_len),
    .rd_addr(rd_addr), .tx_byte(tx_byte), .is_crc(is_crc)
  );

  // Request check over received bytes
  mb_crc16 u_rx_crc (
    .clk(clk), .rst(rst), .clr(rx_crc_clr), .en(rx_crc_en),
    .data(rx_b), .crc(rx_crc)
  );

  // Response CRC over emitted bytes
  mb_crc16 u_tx_crc (
    .clk(clk), .rst(rst), .clr(tx_crc_clr), .en(tx_crc_en),
    .data(tx_byte), .crc(tx_crc)
  );

endmodule

`default_nettype wire

// File: test/tb_mb_slave.sv
/*
  Self-checking testbench for the Modbus RTU slave.
  Sends read and write requests, keeps a model of the register image and
  checks every response byte against a reference CRC and the model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mb_slave;

  typedef mb_proto_pkg::byte_t bytes_q_t[$];

  localparam logic [15:0] MAP_BASE     = 16'h0100;
  localparam int          RESP_TIMEOUT = 2000;
  localparam int          QUIET_CYCLES = 50;

  logic                clk;
  logic                rst;
  mb_proto_pkg::byte_t rx_b;
  logic                rx_b_v;
  logic                frame_start;
  logic                frame_end;
  mb_proto_pkg::byte_t tx_b;
  logic                tx_b_v;
  logic                tx_b_rdy;
  logic                stat_crc_err;

  logic [15:0] model [64];
  bytes_q_t    exp_q;
  int          byte_idx;
  logic        prev_rdy;
  logic        rdy_random;

  mb_slave_top DUT (
    .clk(clk), .rst(rst), .cfg_map_base(MAP_BASE),
    .rx_b(rx_b), .rx_b_v(rx_b_v), .frame_start(frame_start), .frame_end(frame_end),
    .tx_b(tx_b), .tx_b_v(tx_b_v), .tx_b_rdy(tx_b_rdy), .stat_crc_err(stat_crc_err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ====================
  // Reference model
  // ====================

  // Bitwise CRC-16/MODBUS over the whole byte queue
  function automatic logic [15:0] ref_crc(input bytes_q_t data);
    logic [15:0] c;
    c = 16'hFFFF;
    foreach (data[i]) begin
      c = c ^ {8'h00, data[i]};
      repeat (8) begin
        c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
      end
    end
    return c;
  endfunction

  function automatic bytes_q_t make_req(input logic [7:0] st, input logic [7:0] fc,
                                        input logic [15:0] addr, input logic [15:0] val);
    bytes_q_t    q;
    logic [15:0] c;
    q.push_back(st);
    q.push_back(fc);
    q.push_back(addr[15:8]);
    q.push_back(addr[7:0]);
    q.push_back(val[15:8]);
    q.push_back(val[7:0]);
    c = ref_crc(q);
    q.push_back(c[7:0]);
    q.push_back(c[15:8]);
    return q;
  endfunction

  function automatic bytes_q_t expect_resp(input bytes_q_t req);
    bytes_q_t    r;
    logic [15:0] addr;
    logic [15:0] val;
    logic [15:0] ofs;
    logic [15:0] c;
    addr = {req[2], req[3]};
    val  = {req[4], req[5]};
    if (req[1] == 8'h06) begin
      for (int i = 0; i < 6; i++) begin
        r.push_back(req[i]);
      end
    end else begin
      r.push_back(req[0]);
      r.push_back(req[1]);
      r.push_back(8'(2 * val));
      for (int k = 0; k < int'(val); k++) begin
        ofs = addr + 16'(k) - MAP_BASE;
        r.push_back(model[ofs[5:0]][15:8]);
        r.push_back(model[ofs[5:0]][7:0]);
      end
    end
    c = ref_crc(r);
    r.push_back(c[7:0]);
    r.push_back(c[15:8]);
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // ====================
  // Response monitor
  // ====================

  always @(negedge clk) begin
    if (!rst) begin
      if (tx_b_v === 1'b1) begin
        assert (prev_rdy === 1'b1)
          else abort_run("tx_b_v came after a cycle with tx_b_rdy low");
        assert (exp_q.size() > 0)
          else abort_run($sformatf("Unexpected response byte %h at %0t", tx_b, $time));
        assert (tx_b === exp_q[0])
          else abort_run($sformatf("** Error at %0t: response byte %0d is %h, expected %h",
                                   $time, byte_idx, tx_b, exp_q[0]));
        void'(exp_q.pop_front());
        byte_idx++;
      end
      prev_rdy = tx_b_rdy;
    end
  end

  // Flow control from the link side
  always @(posedge clk) begin
    #1;
    tx_b_rdy = rdy_random ? 1'(($urandom % 2) != 0) : 1'b1;
  end

  // ====================
  // Stimulus tasks
  // ====================

  task automatic send_frame(input bytes_q_t frame);
    foreach (frame[i]) begin
      @(posedge clk);
      #1;
      rx_b        = frame[i];
      rx_b_v      = 1'b1;
      frame_start = (i == 0);
    end
    @(posedge clk);
    #1;
    rx_b_v      = 1'b0;
    frame_start = 1'b0;
    frame_end   = 1'b1;
    @(posedge clk);
    #1;
    frame_end = 1'b0;
  endtask

  task automatic wait_response();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      assert (cycles <= RESP_TIMEOUT)
        else abort_run("Response did not complete within 2000 cycles");
    end
    // Idle gap lets the slave return to idle
    repeat (4) @(posedge clk);
  endtask

  task automatic run_request(input bytes_q_t req);
    exp_q    = expect_resp(req);
    byte_idx = 0;
    send_frame(req);
    wait_response();
  endtask

  task automatic do_write(input logic [15:0] addr, input logic [15:0] val);
    logic [15:0] ofs;
    run_request(make_req(8'($urandom), 8'h06, addr, val));
    ofs = addr - MAP_BASE;
    model[ofs[5:0]] = val;
  endtask

  task automatic do_read(input logic [15:0] addr, input logic [15:0] qty);
    run_request(make_req(8'($urandom), 8'h03, addr, qty));
  endtask

  // Frame must be dropped and any tx_b_v trips the monitor
  task automatic expect_silence(input bytes_q_t frame, input logic err_flag);
    exp_q.delete();
    send_frame(frame);
    repeat (QUIET_CYCLES) @(posedge clk);
    assert (stat_crc_err === err_flag)
      else abort_run($sformatf("** Error at %0t: stat_crc_err is %b, expected %b",
                               $time, stat_crc_err, err_flag));
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    bytes_q_t frame;
    logic [15:0] c;
    void'($urandom(22725));
    rst         = 1'b1;
    rx_b        = '0;
    rx_b_v      = 1'b0;
    frame_start = 1'b0;
    frame_end   = 1'b0;
    tx_b_rdy    = 1'b1;
    rdy_random  = 1'b0;
    prev_rdy    = 1'b0;
    byte_idx    = 0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (tx_b_v === 1'b0 && stat_crc_err === 1'b0)
      else abort_run($sformatf("** Error at %0t: tx_b_v is %b, stat_crc_err is %b after reset",
                               $time, tx_b_v, stat_crc_err));

    // Write single echoes
    repeat (16) begin
      do_write(16'($urandom), 16'($urandom));
    end

    // Whole image, then random reads with wrap
    do_read(MAP_BASE, 16'd32);
    do_read(MAP_BASE + 16'd32, 16'd32);
    do_read(MAP_BASE + 16'd60, 16'd8);
    repeat (12) begin
      do_read(MAP_BASE + 16'($urandom % 64), 16'(1 + $urandom % 32));
    end

    // Dropped requests leave the error flag alone
    expect_silence(make_req(8'h11, 8'h01, MAP_BASE, 16'd4), 1'b0);
    expect_silence(make_req(8'h11, 8'h03, MAP_BASE, 16'd0), 1'b0);
    frame = make_req(8'h11, 8'h03, MAP_BASE, 16'd33);
    expect_silence(frame, 1'b0);
    frame.delete();
    frame.push_back(8'h11);
    frame.push_back(8'h03);
    frame.push_back(8'h01);
    frame.push_back(8'h00);
    frame.push_back(8'h02);
    c = ref_crc(frame);
    frame.push_back(c[7:0]);
    frame.push_back(c[15:8]);
    expect_silence(frame, 1'b0);
    frame = make_req(8'h11, 8'h03, MAP_BASE, 16'd2);
    frame.push_back(8'h00);
    expect_silence(frame, 1'b0);
    do_read(MAP_BASE + 16'd5, 16'd10);

    // A write with a corrupted CRC must not land
    frame = make_req(8'h22, 8'h06, MAP_BASE + 16'd3, 16'hBEEF);
    frame[6] = frame[6] ^ 8'h5A;
    expect_silence(frame, 1'b1);
    do_read(MAP_BASE, 16'd8);

    // Random back-pressure on the transmit side
    rdy_random = 1'b1;
    repeat (10) begin
      do_read(16'($urandom), 16'(1 + $urandom % 32));
    end
    do_write(MAP_BASE + 16'd63, 16'h1234);
    do_read(MAP_BASE + 16'd62, 16'd4);
    rdy_random = 1'b0;

    assert (stat_crc_err === 1'b1)
      else abort_run($sformatf("** Error at %0t: stat_crc_err is %b, expected 1",
                               $time, stat_crc_err));

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
src/mb_proto_pkg.sv
src/mb_map_pkg.sv
src/mb_crc16.sv
src/mb_byte_counter.sv
src/mb_rx_fields.sv
src/mb_holding_regs.sv
src/mb_tx_mux.sv
src/mb_frame_fsm.sv
src/mb_slave_top.sv
test/tb_mb_slave.sv

// File: Bender.yml
package:
  name: mb_slave

sources:
  - src/mb_proto_pkg.sv
  - src/mb_map_pkg.sv
  - src/mb_crc16.sv
  - src/mb_byte_counter.sv
  - src/mb_rx_fields.sv
  - src/mb_holding_regs.sv
  - src/mb_tx_mux.sv
  - src/mb_frame_fsm.sv
  - src/mb_slave_top.sv
  - target: test
    files:
      - test/tb_mb_slave.sv
